/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // integer register width, RV32I
  localparam int unsigned xw = 32;
  // register index width, 32 GPRs
  localparam int unsigned rw = 5;

  // major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    // only EBREAK is decoded here
    OPC_SYSTEM = 7'b1110011
  } opc_t;

  // alu operation
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    // operand b straight through, for LUI
    ALU_PASS_B
  } alu_op_t;

  // write back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    // pc + 4, link for JAL
    WB_PCN,
    WB_NONE
  } wb_t;

endpackage

`default_nettype wire

/* rtl/rv_bus_pkg.sv */
`default_nettype none

package rv_bus_pkg;

  // word address width
  localparam int unsigned aw = 10;
  // data width, one full word per access
  localparam int unsigned dw = 32;

  // current owner of the memory port
  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_HOST,
    GNT_DATA,
    GNT_FETCH
  } grant_t;

endpackage

`default_nettype wire

/* rtl/rv_gpr.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_gpr (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         we,
  input  logic [rv_isa_pkg::rw-1:0]    a_rs1,
  input  logic [rv_isa_pkg::rw-1:0]    a_rs2,
  input  logic [rv_isa_pkg::rw-1:0]    a_rd,
  input  logic [rv_isa_pkg::xw-1:0]    d_rd,
  output logic [rv_isa_pkg::xw-1:0]    d_rs1,
  output logic [rv_isa_pkg::xw-1:0]    d_rs2
);

  import rv_isa_pkg::*;

  logic [xw-1:0] regs [0:2**rw-1];

  // write port, x0 never written
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 2**rw; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (a_rd != '0)) begin
      regs[a_rd] <= d_rd;
    end
  end

  // async read, x0 forced to zero
  assign d_rs1 = (a_rs1 == '0) ? '0 : regs[a_rs1];
  assign d_rs2 = (a_rs2 == '0) ? '0 : regs[a_rs2];

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_isa_pkg::alu_op_t          op,
  input  logic [rv_isa_pkg::xw-1:0]    rs1,
  input  logic [rv_isa_pkg::xw-1:0]    rs2,
  output logic [rv_isa_pkg::xw-1:0]    rd,
  output logic [rv_isa_pkg::xw-1:0]    sum,
  output logic                         eq
);

  import rv_isa_pkg::*;

  logic          lt;

  // adder always live, used for load/store address
  assign sum = rs1 + rs2;

  // signed less than
  assign lt = $signed(rs1) < $signed(rs2);

  // operand compare for BEQ/BNE
  assign eq = (rs1 == rs2);

  always_comb begin
    case (op)
      ALU_ADD: begin
        rd = sum;
      end
      ALU_SUB: begin
        rd = rs1 - rs2;
      end
      ALU_AND: begin
        rd = rs1 & rs2;
      end
      ALU_OR: begin
        rd = rs1 | rs2;
      end
      ALU_XOR: begin
        rd = rs1 ^ rs2;
      end
      ALU_SLT: begin
        rd = {{(xw-1){1'b0}}, lt};
      end
      default: begin
        // pass b, LUI
        rd = rs2;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter logic [rv_isa_pkg::xw-1:0] PC0 = '0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  // fetch master, read only
  output logic                         if_req,
  output logic [rv_bus_pkg::aw-1:0]    if_adr,
  input  logic [rv_bus_pkg::dw-1:0]    if_rdt,
  input  logic                         if_ack,
  // load/store master
  output logic                         ls_req,
  output logic                         ls_wen,
  output logic [rv_bus_pkg::aw-1:0]    ls_adr,
  output logic [rv_bus_pkg::dw-1:0]    ls_wdt,
  input  logic [rv_bus_pkg::dw-1:0]    ls_rdt,
  input  logic                         ls_ack,
  output logic                         halt
);

  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM, ST_HALT} st_t;

  st_t           state;
  logic [xw-1:0] pc;
  // latched instruction
  logic [xw-1:0] ir;
  // decoded fields
  opc_t          opc;
  logic [xw-1:0] imm;
  logic          sel_imm;
  alu_op_t       alu_op;
  wb_t           wb;
  logic          is_br;
  logic          br_ne;
  logic          is_jal;
  // datapath
  logic [xw-1:0] gpr_rs1;
  logic [xw-1:0] gpr_rs2;
  logic [xw-1:0] gpr_rd;
  logic          gpr_we;
  logic [xw-1:0] alu_rd;
  logic [xw-1:0] alu_sum;
  logic          alu_eq;
  logic [xw-1:0] pc_inc;
  logic [xw-1:0] pc_tgt;
  logic          br_tkn;

  // funct3 to alu op, sub only for OP with bit 30
  function automatic alu_op_t f3_op(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return sub ? ALU_SUB : ALU_ADD;
    endcase
  endfunction

  ////////////////////
  // decode
  ////////////////////

  assign opc = opc_t'(ir[6:0]);

  always_comb begin
    // defaults match loads, I-type immediate
    imm     = {{20{ir[31]}}, ir[31:20]};
    sel_imm = 1'b1;
    alu_op  = ALU_ADD;
    wb      = WB_NONE;
    is_br   = 1'b0;
    br_ne   = 1'b0;
    is_jal  = 1'b0;
    case (opc)
      OPC_LUI: begin
        imm    = {ir[31:12], 12'b0};
        alu_op = ALU_PASS_B;
        wb     = WB_ALU;
      end
      OPC_OP_IMM: begin
        alu_op = f3_op(ir[14:12], 1'b0);
        wb     = WB_ALU;
      end
      OPC_OP: begin
        sel_imm = 1'b0;
        alu_op  = f3_op(ir[14:12], ir[30]);
        wb      = WB_ALU;
      end
      OPC_BRANCH: begin
        // alu compares rs1/rs2, target from pc adder
        imm     = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
        sel_imm = 1'b0;
        is_br   = 1'b1;
        br_ne   = ir[12];
      end
      OPC_JAL: begin
        imm    = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        is_jal = 1'b1;
        wb     = WB_PCN;
      end
      OPC_LOAD: begin
        wb = WB_MEM;
      end
      OPC_STORE: begin
        imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      end
      default: begin
        // SYSTEM halts in the fsm, rest is a nop
        wb = WB_NONE;
      end
    endcase
  end

  ////////////////////
  // datapath
  ////////////////////

  // write back mux
  always_comb begin
    case (wb)
      WB_MEM:  gpr_rd = ls_rdt;
      WB_PCN:  gpr_rd = pc_inc;
      default: gpr_rd = alu_rd;
    endcase
  end

  // alu results in EXEC, load data on ack
  assign gpr_we = ((state == ST_EXEC) && ((wb == WB_ALU) || (wb == WB_PCN)))
               || ((state == ST_MEM) && ls_ack && (wb == WB_MEM));

  rv_gpr i_rv_gpr (
    .clk   (clk),
    .rst   (rst),
    .we    (gpr_we),
    .a_rs1 (ir[19:15]),
    .a_rs2 (ir[24:20]),
    .a_rd  (ir[11:7]),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  rv_alu i_rv_alu (
    .op  (alu_op),
    .rs1 (gpr_rs1),
    .rs2 (sel_imm ? imm : gpr_rs2),
    .rd  (alu_rd),
    .sum (alu_sum),
    .eq  (alu_eq)
  );

  // next pc candidates
  assign pc_inc = pc + xw'(4);
  assign pc_tgt = pc + imm;
  assign br_tkn = is_br && (alu_eq ^ br_ne);

  ////////////////////
  // sequencing
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= ST_FETCH;
      pc    <= PC0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (if_ack) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (opc == OPC_SYSTEM) begin
            state <= ST_HALT;
          end else begin
            pc    <= (is_jal || br_tkn) ? pc_tgt : pc_inc;
            state <= ((opc == OPC_LOAD) || (opc == OPC_STORE)) ? ST_MEM : ST_FETCH;
          end
        end
        ST_MEM: begin
          if (ls_ack) begin
            state <= ST_FETCH;
          end
        end
        default: begin
          // stuck until reset
          state <= ST_HALT;
        end
      endcase
    end
  end

  // instruction latch
  always_ff @(posedge clk) begin
    if ((state == ST_FETCH) && if_ack) begin
      ir <= if_rdt;
    end
  end

  // bus side, byte address to word address
  assign if_req = (state == ST_FETCH) && run;
  assign if_adr = pc[aw+1:2];
  assign ls_req = (state == ST_MEM);
  assign ls_wen = (opc == OPC_STORE);
  assign ls_adr = alu_sum[aw+1:2];
  assign ls_wdt = gpr_rs2;
  assign halt   = (state == ST_HALT);

endmodule

`default_nettype wire

/* rtl/rv_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_arbiter #(
  parameter int unsigned AW = rv_bus_pkg::aw
) (
  input  logic                         clk,
  input  logic                         rst,
  // host master
  input  logic                         hst_req,
  input  logic                         hst_wen,
  input  logic [rv_bus_pkg::aw-1:0]    hst_adr,
  input  logic [rv_bus_pkg::dw-1:0]    hst_wdt,
  output logic [rv_bus_pkg::dw-1:0]    hst_rdt,
  output logic                         hst_ack,
  // load/store master
  input  logic                         ls_req,
  input  logic                         ls_wen,
  input  logic [rv_bus_pkg::aw-1:0]    ls_adr,
  input  logic [rv_bus_pkg::dw-1:0]    ls_wdt,
  output logic [rv_bus_pkg::dw-1:0]    ls_rdt,
  output logic                         ls_ack,
  // fetch master, no writes
  input  logic                         if_req,
  input  logic [rv_bus_pkg::aw-1:0]    if_adr,
  output logic [rv_bus_pkg::dw-1:0]    if_rdt,
  output logic                         if_ack,
  // memory port
  output logic                         mem_en,
  output logic                         mem_wen,
  output logic [AW-1:0]                mem_adr,
  output logic [rv_bus_pkg::dw-1:0]    mem_wdt,
  input  logic [rv_bus_pkg::dw-1:0]    mem_rdt
);

  import rv_bus_pkg::*;

  grant_t owner;
  grant_t winner;
  // access issued, data due this cycle
  logic   pending;
  logic   sel_wen;

  ////////////////////
  // grant
  ////////////////////

  // fixed priority, host first
  assign winner = hst_req ? GNT_HOST :
                  ls_req  ? GNT_DATA :
                  if_req  ? GNT_FETCH : GNT_NONE;

  // idle -> grant -> pending -> idle
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      owner   <= GNT_NONE;
      pending <= 1'b0;
    end else if (pending) begin
      owner   <= GNT_NONE;
      pending <= 1'b0;
    end else if (owner != GNT_NONE) begin
      pending <= 1'b1;
    end else begin
      owner <= winner;
    end
  end

  ////////////////////
  // memory side mux
  ////////////////////

  always_comb begin
    case (owner)
      GNT_HOST: begin
        sel_wen = hst_wen;
        mem_adr = hst_adr[AW-1:0];
        mem_wdt = hst_wdt;
      end
      GNT_DATA: begin
        sel_wen = ls_wen;
        mem_adr = ls_adr[AW-1:0];
        mem_wdt = ls_wdt;
      end
      GNT_FETCH: begin
        sel_wen = 1'b0;
        mem_adr = if_adr[AW-1:0];
        mem_wdt = '0;
      end
      default: begin
        sel_wen = 1'b0;
        mem_adr = '0;
        mem_wdt = '0;
      end
    endcase
  end

  // one access cycle per grant
  assign mem_en  = (owner != GNT_NONE) && !pending;
  assign mem_wen = mem_en && sel_wen;

  // ack pulse and read data back to the owner only
  assign hst_ack = pending && (owner == GNT_HOST);
  assign ls_ack  = pending && (owner == GNT_DATA);
  assign if_ack  = pending && (owner == GNT_FETCH);
  assign hst_rdt = hst_ack ? mem_rdt : '0;
  assign ls_rdt  = ls_ack ? mem_rdt : '0;
  assign if_rdt  = if_ack ? mem_rdt : '0;

endmodule

`default_nettype wire

/* rtl/rv_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_sram #(
  parameter int unsigned MEM_WORDS = 1024,
  parameter int unsigned AW        = $clog2(MEM_WORDS)
) (
  input  logic                         clk,
  input  logic                         en,
  input  logic                         wen,
  input  logic [AW-1:0]                adr,
  input  logic [rv_bus_pkg::dw-1:0]    wdt,
  output logic [rv_bus_pkg::dw-1:0]    rdt
);

  import rv_bus_pkg::*;

  // word storage, contents undefined after reset
  logic [dw-1:0] mem [0:MEM_WORDS-1];

  // single port, write or read per enabled cycle
  always_ff @(posedge clk) begin
    if (en) begin
      if (wen) begin
        mem[adr] <= wdt;
      end else begin
        // read data held until next read
        rdt <= mem[adr];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_soc #(
  parameter int unsigned               MEM_WORDS = 1024,
  parameter logic [rv_isa_pkg::xw-1:0] PC0       = '0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  // host port
  input  logic                         hst_req,
  input  logic                         hst_wen,
  input  logic [rv_bus_pkg::aw-1:0]    hst_adr,
  input  logic [rv_bus_pkg::dw-1:0]    hst_wdt,
  output logic [rv_bus_pkg::dw-1:0]    hst_rdt,
  output logic                         hst_ack,
  output logic                         halt
);

  import rv_bus_pkg::*;

  // memory address bits follow depth
  localparam int unsigned AW = $clog2(MEM_WORDS);

  // fetch bus
  logic          if_req;
  logic [aw-1:0] if_adr;
  logic [dw-1:0] if_rdt;
  logic          if_ack;
  // load/store bus
  logic          ls_req;
  logic          ls_wen;
  logic [aw-1:0] ls_adr;
  logic [dw-1:0] ls_wdt;
  logic [dw-1:0] ls_rdt;
  logic          ls_ack;
  // memory port
  logic          mem_en;
  logic          mem_wen;
  logic [AW-1:0] mem_adr;
  logic [dw-1:0] mem_wdt;
  logic [dw-1:0] mem_rdt;

  rv_core #(
    .PC0 (PC0)
  ) i_rv_core (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack),
    .halt   (halt)
  );

  rv_mem_arbiter #(
    .AW (AW)
  ) i_rv_mem_arbiter (
    .clk     (clk),
    .rst     (rst),
    .hst_req (hst_req),
    .hst_wen (hst_wen),
    .hst_adr (hst_adr),
    .hst_wdt (hst_wdt),
    .hst_rdt (hst_rdt),
    .hst_ack (hst_ack),
    .ls_req  (ls_req),
    .ls_wen  (ls_wen),
    .ls_adr  (ls_adr),
    .ls_wdt  (ls_wdt),
    .ls_rdt  (ls_rdt),
    .ls_ack  (ls_ack),
    .if_req  (if_req),
    .if_adr  (if_adr),
    .if_rdt  (if_rdt),
    .if_ack  (if_ack),
    .mem_en  (mem_en),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

  rv_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) i_rv_sram (
    .clk (clk),
    .en  (mem_en),
    .wen (mem_wen),
    .adr (mem_adr),
    .wdt (mem_wdt),
    .rdt (mem_rdt)
  );

endmodule

`default_nettype wire

/* verif/rv_soc_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_soc_assertions (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_bus_pkg::grant_t   owner,
  input  logic                 pending,
  input  logic                 mem_en,
  input  logic                 hst_ack,
  input  logic                 ls_ack,
  input  logic                 if_ack
);

  import rv_bus_pkg::*;

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // owner goes back to idle before another master takes over
  one_owner: assert property (@(posedge clk) disable iff (rst)
    (owner != GNT_NONE) |=> (owner == $past(owner)) || (owner == GNT_NONE))
    else begin
      $error("memory handed from one master to another without going idle");
      fail_cnt++;
    end

  // granted master gets the ack next cycle, nobody else
  ack_after_grant: assert property (@(posedge clk) disable iff (rst)
    mem_en |=> (hst_ack == (owner == GNT_HOST)) && (ls_ack == (owner == GNT_DATA))
               && (if_ack == (owner == GNT_FETCH)))
    else begin
      $error("ack did not follow the grant by one cycle");
      fail_cnt++;
    end

  // owner held from grant through the ack cycle
  owner_held: assert property (@(posedge clk) disable iff (rst)
    mem_en |=> (owner == $past(owner)))
    else begin
      $error("owner changed while an access was in flight");
      fail_cnt++;
    end

  // no grant taken in the pending cycle
  no_grant_pending: assert property (@(posedge clk) disable iff (rst)
    pending |=> !mem_en)
    else begin
      $error("memory enabled right after a pending access");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* verif/rv_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_soc_tb;

  import rv_bus_pkg::*;

  localparam int unsigned MEM_WORDS  = 1024;
  // programs take a few hundred cycles, host traffic under two thousand
  localparam int unsigned MAX_CYCLES = 20000;
  // result areas, byte addresses
  localparam int unsigned ARITH_RES  = 'h200;
  localparam int unsigned CF_RES     = 'h280;
  localparam int unsigned LS_RES     = 'h300;
  // preloaded region, word addresses, above all results
  localparam int unsigned FILL_BASE  = 832;
  localparam int unsigned FILL_WORDS = 32;
  // major opcodes
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_LD  = 7'b0000011;
  localparam logic [6:0] OP_ST  = 7'b0100011;
  localparam logic [6:0] OP_BR  = 7'b1100011;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [31:0] EBREAK = 32'h00100073;

  logic          clk;
  logic          rst;
  logic          run;
  logic          hst_req;
  logic          hst_wen;
  logic [aw-1:0] hst_adr;
  logic [dw-1:0] hst_wdt;
  logic [dw-1:0] hst_rdt;
  logic          hst_ack;
  logic          halt;

  int unsigned   cycles = 0;
  int unsigned   errors = 0;
  // program image and expected result words
  logic [31:0]   prog [$];
  logic [31:0]   exp_q [$];

  rv_soc #(
    .MEM_WORDS (MEM_WORDS),
    .PC0       ('0)
  ) i_rv_soc (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .hst_req (hst_req),
    .hst_wen (hst_wen),
    .hst_adr (hst_adr),
    .hst_wdt (hst_wdt),
    .hst_rdt (hst_rdt),
    .hst_ack (hst_ack),
    .halt    (halt)
  );

  bind rv_mem_arbiter rv_soc_assertions i_rv_soc_assertions (
    .clk     (clk),
    .rst     (rst),
    .owner   (owner),
    .pending (pending),
    .mem_en  (mem_en),
    .hst_ack (hst_ack),
    .ls_ack  (ls_ack),
    .if_ack  (if_ack)
  );

  always #4 clk = ~clk;

  function automatic int unsigned assertion_failures();
    return i_rv_soc.i_rv_mem_arbiter.i_rv_soc_assertions.fail_cnt;
  endfunction

  function automatic void report_counts();
    $display("errors: %0d check, %0d assertion", errors, assertion_failures());
  endfunction

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout after %0d cycles, DUT stopped responding", cycles);
      report_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////
  // encoders
  ////////////////////

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  // SW rs2, imm(rs1)
  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_ST};
  endfunction

  function automatic logic [31:0] enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // preload pattern, whole address mixed in
  function automatic logic [31:0] fill_value(input int unsigned adr);
    return 32'h5A00_0000 ^ (adr * 32'h9E37_79B1) ^ (adr << 16);
  endfunction

  ////////////////////
  // host port
  ////////////////////

  // ack sampled at negedge, returns at posedge + 1
  task automatic wait_host_ack(output logic [31:0] data);
    @(negedge clk);
    while (!hst_ack) begin
      @(negedge clk);
    end
    data = hst_rdt;
    @(posedge clk);
    #1;
  endtask

  task automatic write_word(input int unsigned adr, input logic [31:0] data);
    logic [31:0] unused;
    hst_req = 1'b1;
    hst_wen = 1'b1;
    hst_adr = adr[aw-1:0];
    hst_wdt = data;
    wait_host_ack(unused);
    hst_req = 1'b0;
    hst_wen = 1'b0;
  endtask

  task automatic read_word(input int unsigned adr, output logic [31:0] data);
    hst_req = 1'b1;
    hst_wen = 1'b0;
    hst_adr = adr[aw-1:0];
    wait_host_ack(data);
    hst_req = 1'b0;
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  ////////////////////
  // core control
  ////////////////////

  task automatic reset_dut();
    rst = 1'b1;
    run = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    assert (!halt && !hst_ack) else begin
      errors++;
      $display("halt or host ack active right after reset");
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      write_word(i, prog[i]);
    end
  endtask

  // halt sampled at negedge, run dropped afterwards
  task automatic wait_halt();
    @(negedge clk);
    while (!halt) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    run = 1'b0;
  endtask

  task automatic check_results(input string name, input int unsigned base);
    logic [31:0] got;
    for (int i = 0; i < exp_q.size(); i++) begin
      read_word(base / 4 + i, got);
      compare_word($sformatf("%s[%0d]", name, i), exp_q[i], got);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic host_round_trip();
    logic [31:0] words [16];
    logic [31:0] got;
    for (int i = 0; i < 16; i++) begin
      words[i] = $urandom();
      write_word(64 + i, words[i]);
    end
    for (int i = 0; i < 16; i++) begin
      read_word(64 + i, got);
      compare_word($sformatf("host_round_trip[%0d]", i), words[i], got);
    end
  endtask

  task automatic arith_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    // x1 = lui + addi, x2 = -256, x3 = 100
    a = {20'h12345, 12'h000} + 32'h678;
    b = 32'd0 - 32'd256;
    c = 32'd100;
    prog.delete();
    prog.push_back(enc_lui(1, 20'h12345));
    prog.push_back(enc_i(OP_IMM, 3'b000, 1, 1, 32'h678));
    prog.push_back(enc_i(OP_IMM, 3'b000, 2, 0, b));
    prog.push_back(enc_i(OP_IMM, 3'b000, 3, 0, c));
    prog.push_back(enc_r(7'h00, 3'b000, 4, 1, 3));
    prog.push_back(enc_r(7'h20, 3'b000, 5, 3, 2));
    prog.push_back(enc_r(7'h00, 3'b111, 6, 1, 2));
    prog.push_back(enc_r(7'h00, 3'b110, 7, 1, 3));
    prog.push_back(enc_r(7'h00, 3'b100, 8, 1, 2));
    prog.push_back(enc_r(7'h00, 3'b010, 9, 2, 3));
    prog.push_back(enc_r(7'h00, 3'b010, 10, 3, 2));
    for (int r = 1; r <= 10; r++) begin
      prog.push_back(enc_sw(r, 0, ARITH_RES + 4 * (r - 1)));
    end
    prog.push_back(EBREAK);
    exp_q = '{a, b, c, a + c, c - b, a & b, a | c, a ^ b,
              ($signed(b) < $signed(c)) ? 32'd1 : 32'd0,
              ($signed(c) < $signed(b)) ? 32'd1 : 32'd0};
    reset_dut();
    load_program();
    run = 1'b1;
    wait_halt();
    check_results("arith", ARITH_RES);
  endtask

  task automatic control_test();
    logic [31:0] link;
    prog.delete();
    prog.push_back(enc_i(OP_IMM, 3'b000, 1, 0, 7));
    prog.push_back(enc_i(OP_IMM, 3'b000, 2, 0, 7));
    prog.push_back(enc_i(OP_IMM, 3'b000, 3, 0, 9));
    // marker value
    prog.push_back(enc_i(OP_IMM, 3'b000, 4, 0, 1));
    // each branch jumps over one marker store
    prog.push_back(enc_br(3'b000, 1, 2, 8));
    prog.push_back(enc_sw(4, 0, CF_RES));
    prog.push_back(enc_br(3'b000, 1, 3, 8));
    prog.push_back(enc_sw(4, 0, CF_RES + 4));
    prog.push_back(enc_br(3'b001, 1, 3, 8));
    prog.push_back(enc_sw(4, 0, CF_RES + 8));
    prog.push_back(enc_br(3'b001, 1, 2, 8));
    prog.push_back(enc_sw(4, 0, CF_RES + 12));
    link = 32'(4 * prog.size() + 4);
    prog.push_back(enc_jal(5, 8));
    prog.push_back(enc_sw(4, 0, CF_RES + 16));
    prog.push_back(enc_sw(5, 0, CF_RES + 20));
    prog.push_back(EBREAK);
    // marker stored only when the branch falls through
    exp_q = '{(7 == 7) ? 32'd0 : 32'd1, (7 == 9) ? 32'd0 : 32'd1,
              (7 != 9) ? 32'd0 : 32'd1, (7 != 7) ? 32'd0 : 32'd1,
              32'd0, link};
    reset_dut();
    load_program();
    for (int i = 0; i < 6; i++) begin
      write_word(CF_RES / 4 + i, 32'd0);
    end
    run = 1'b1;
    wait_halt();
    check_results("control", CF_RES);
  endtask

  task automatic load_store_test();
    logic [31:0] v;
    logic [31:0] got;
    v = {20'hCAFE0, 12'h000} + 32'h123;
    prog.delete();
    prog.push_back(enc_lui(1, 20'hCAFE0));
    prog.push_back(enc_i(OP_IMM, 3'b000, 1, 1, 32'h123));
    prog.push_back(enc_i(OP_IMM, 3'b000, 7, 0, LS_RES));
    prog.push_back(enc_sw(1, 7, 0));
    prog.push_back(enc_i(OP_LD, 3'b010, 2, 7, 0));
    prog.push_back(enc_i(OP_IMM, 3'b000, 3, 2, 1));
    prog.push_back(enc_sw(3, 7, 4));
    // countdown loop keeps the core busy
    prog.push_back(enc_i(OP_IMM, 3'b000, 6, 0, 20));
    prog.push_back(enc_i(OP_IMM, 3'b000, 6, 6, 32'hFFFF_FFFF));
    prog.push_back(enc_br(3'b001, 6, 0, 32'hFFFF_FFFC));
    prog.push_back(enc_i(OP_LD, 3'b010, 8, 7, 4));
    prog.push_back(enc_sw(8, 7, 8));
    prog.push_back(enc_sw(6, 7, 12));
    prog.push_back(EBREAK);
    exp_q = '{v, v + 1, v + 1, 32'd0};
    reset_dut();
    load_program();
    for (int i = 0; i < FILL_WORDS; i++) begin
      write_word(FILL_BASE + i, fill_value(FILL_BASE + i));
    end
    run = 1'b1;
    // core fetching by now, host read lands on a busy bus
    repeat (10) @(posedge clk);
    #1;
    read_word(FILL_BASE + 3, got);
    assert (!halt) else begin
      errors++;
      $display("core halted before the concurrent host read completed");
    end
    compare_word("host_during_run", fill_value(FILL_BASE + 3), got);
    wait_halt();
    check_results("load_store", LS_RES);
    // untouched region after halt
    for (int i = 0; i < FILL_WORDS; i++) begin
      read_word(FILL_BASE + i, got);
      compare_word($sformatf("fill[%0d]", i), fill_value(FILL_BASE + i), got);
    end
  endtask

  initial begin
    void'($urandom(27));
    clk     = 1'b0;
    rst     = 1'b1;
    run     = 1'b0;
    hst_req = 1'b0;
    hst_wen = 1'b0;
    hst_adr = '0;
    hst_wdt = '0;
    reset_dut();
    host_round_trip();
    arith_test();
    control_test();
    load_store_test();
    report_counts();
    if ((errors == 0) && (assertion_failures() == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/rv_isa_pkg.sv
rtl/rv_bus_pkg.sv
rtl/rv_gpr.sv
rtl/rv_alu.sv
rtl/rv_core.sv
rtl/rv_mem_arbiter.sv
rtl/rv_sram.sv
rtl/rv_soc.sv
verif/rv_soc_assertions.sv
verif/rv_soc_tb.sv
